// ==== Makefile ====
TOP = tb_id_stage

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -Mdir obj_dir -f project.f

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "sim failed" sim.log; then exit 1; fi
	@grep -q "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== dv/tb_id_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_id_stage;

  import id_pkg::*;

  ////////////////////////////////////////
  // Run length
  ////////////////////////////////////////

  localparam int RESET_CYCLES   = 4;
  localparam int N_ILLEGAL      = 24;
  localparam int N_LEGAL        = 28;
  localparam int N_FWD          = 40;
  localparam int DRAIN          = 3;
  localparam int LEN_HALT_KILL  = 7 + DRAIN;
  localparam int LEN_X0         = 7 + DRAIN;
  localparam int LEN_STALL      = 6 + DRAIN;
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + N_ILLEGAL + N_LEGAL + N_FWD + 3 * DRAIN
                                  + LEN_HALT_KILL + LEN_X0 + LEN_STALL + 200;

  // Decode vector layout
  // {illegal, csr_op[1:0], alu, mul, lsu, rf_we, ecall, ebrk, mret, wfi, fencei}
  localparam logic [11:0] DEC_ALU     = 12'b0_00_1_0_0_1_00000;
  localparam logic [11:0] DEC_MUL     = 12'b0_00_0_1_0_1_00000;
  localparam logic [11:0] DEC_LOAD    = 12'b0_00_0_0_1_1_00000;
  localparam logic [11:0] DEC_STORE   = 12'b0_00_0_0_1_0_00000;
  localparam logic [11:0] DEC_ILLEGAL = 12'b1_00_0_0_0_0_00000;

  // ADD x5, x0, x0
  localparam logic [31:0] ADD_X5_X0_X0 = 32'h0000_02b3;

  // What the ID/EX register should hold after the next load
  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
    logic [11:0] dec;
    rf_data_t    op_a;
    rf_data_t    op_b;
  } expect_t;

  logic        clk;
  logic        arst_n;
  if_id_pipe_t if_id_pipe;
  wb_t         wb;
  ctrl_t       ctrl;
  logic        ex_ready;
  logic        id_ready;
  logic        id_valid;
  id_ex_pipe_t id_ex_pipe;

  // Inputs for the coming cycle, filled in by the tests
  if_id_pipe_t nxt_if;
  wb_t         nxt_wb;
  ctrl_t       nxt_ctrl;
  logic        nxt_ex_ready;
  logic [11:0] nxt_dec;

  expect_t     cur_q;
  expect_t     exp_q;
  rf_data_t    shadow [RF_DEPTH];
  logic [31:0] pc_next;
  integer      seed;
  int          err_cnt;
  int          err_mark;
  int          n_pass;
  int          n_fail;
  int          cycle_cnt = 0;
  logic        exp_ready;
  logic        exp_valid;

  id_stage dut (
    .clk          (clk),
    .arst_n_i     (arst_n),
    .if_id_pipe_i (if_id_pipe),
    .wb_i         (wb),
    .ctrl_i       (ctrl),
    .ex_ready_i   (ex_ready),
    .id_ready_o   (id_ready),
    .id_valid_o   (id_valid),
    .id_ex_pipe_o (id_ex_pipe)
  );

  always #10 clk = ~clk;

  // Kill wins over halt and halt alone freezes the stage
  always_comb begin
    if (ctrl.kill_id) begin
      exp_ready = 1'b1;
      exp_valid = 1'b0;
    end else if (ctrl.halt_id) begin
      exp_ready = 1'b0;
      exp_valid = 1'b0;
    end else begin
      exp_ready = ex_ready;
      exp_valid = if_id_pipe.instr_valid;
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("sim failed");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  function automatic logic [11:0] dec_vec(decode_t d);
    return {d.illegal_insn, d.csr_op, d.alu_en, d.mul_en, d.lsu_en, d.rf_we,
            d.ecall_insn, d.ebrk_insn, d.mret_insn, d.wfi_insn, d.fencei_insn};
  endfunction

  // Regular code reads x0 as zero and a same-cycle write to any other register is bypassed
  function automatic rf_data_t read_operand(rf_addr_t addr, logic dummy);
    if (addr == '0) return dummy ? shadow[0] : '0;
    if (nxt_wb.we && (nxt_wb.waddr == addr)) return nxt_wb.wdata;
    return shadow[addr];
  endfunction

  // One legal encoding per decoded class with random register fields
  function automatic logic [31:0] legal_instr(int cls);
    logic [31:0] rnd;
    rnd = $random(seed);
    case (cls)
      0:       return {7'h00, rnd[24:15], 3'b000, rnd[11:7], OPCODE_OP};
      1:       return {7'h20, rnd[24:15], 3'b000, rnd[11:7], OPCODE_OP};
      2:       return {7'h01, rnd[24:15], 3'b000, rnd[11:7], OPCODE_OP};
      3:       return {rnd[31:15], 3'b000, rnd[11:7], OPCODE_OPIMM};
      4:       return {rnd[31:15], 3'b010, rnd[11:7], OPCODE_LOAD};
      5:       return {rnd[31:15], 3'b010, rnd[11:7], OPCODE_STORE};
      6:       return 32'h0000_100f;
      7:       return 32'h0000_0073;
      8:       return 32'h0010_0073;
      9:       return 32'h3020_0073;
      10:      return 32'h1050_0073;
      11:      return {rnd[31:15], 3'b001, rnd[11:7], OPCODE_SYSTEM};
      12:      return {rnd[31:15], 3'b010, rnd[11:7], OPCODE_SYSTEM};
      default: return {rnd[31:15], 3'b011, rnd[11:7], OPCODE_SYSTEM};
    endcase
  endfunction

  function automatic logic [11:0] legal_dec(int cls);
    case (cls)
      0, 1, 3: return DEC_ALU;
      2:       return DEC_MUL;
      4:       return DEC_LOAD;
      5:       return DEC_STORE;
      6:       return 12'b0_00_0_0_0_0_00001;
      7:       return 12'b0_00_0_0_0_0_10000;
      8:       return 12'b0_00_0_0_0_0_01000;
      9:       return 12'b0_00_0_0_0_0_00100;
      10:      return 12'b0_00_0_0_0_0_00010;
      11:      return 12'b0_01_0_0_0_1_00000;
      12:      return 12'b0_10_0_0_0_1_00000;
      default: return 12'b0_11_0_0_0_1_00000;
    endcase
  endfunction

  // Major opcodes outside the decoded set with random other bits
  function automatic logic [31:0] illegal_instr();
    logic [31:0] rnd;
    logic [6:0]  opc [8];
    rnd = $random(seed);
    opc = '{7'h37, 7'h17, 7'h6f, 7'h67, 7'h63, 7'h07, 7'h2f, 7'h0b};
    return {rnd[31:7], opc[rnd[2:0]]};
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    err_cnt++;
    $display("ERR %s expected %h actual %h", name, exp, act);
  endtask

  task automatic report_failure(input string msg);
    err_cnt++;
    $display("%s", msg);
  endtask

  task automatic load_instr(input logic [31:0] instr, input logic dummy,
                            input logic [11:0] dec);
    nxt_if.instr_valid = 1'b1;
    nxt_if.instr       = instr;
    nxt_if.dummy       = dummy;
    nxt_if.pc          = pc_next;
    nxt_dec            = dec;
    pc_next            = pc_next + 32'd4;
  endtask

  task automatic go_idle();
    nxt_if.instr_valid = 1'b0;
    nxt_wb             = '0;
    nxt_ctrl           = '0;
    nxt_ex_ready       = 1'b1;
  endtask

  // Advance one clock, update the reference model and drive the next inputs
  task automatic step_cycle();
    expect_t cur;
    @(posedge clk);
    // The writeback of the cycle that just ended now sits in the array
    if (wb.we && ((wb.waddr != '0) || wb.dummy)) begin
      shadow[wb.waddr] = wb.wdata;
    end
    cur.valid = nxt_if.instr_valid && !nxt_ctrl.halt_id && !nxt_ctrl.kill_id;
    cur.pc    = nxt_if.pc;
    cur.dec   = nxt_dec;
    cur.op_a  = read_operand(nxt_if.instr[19:15], nxt_if.dummy);
    cur.op_b  = read_operand(nxt_if.instr[24:20], nxt_if.dummy);
    // The ID/EX register only loads while EX is ready
    if (ex_ready) begin
      exp_q <= cur_q;
    end
    cur_q      <= cur;
    if_id_pipe <= nxt_if;
    wb         <= nxt_wb;
    ctrl       <= nxt_ctrl;
    ex_ready   <= nxt_ex_ready;
  endtask

  task automatic start_test();
    err_mark = err_cnt;
    go_idle();
  endtask

  task automatic close_test(input string name);
    go_idle();
    repeat (DRAIN) step_cycle();
    if (err_cnt == err_mark) begin
      n_pass++;
      $display("test %s: ok", name);
    end else begin
      n_fail++;
      $display("test %s: %0d errors", name, err_cnt - err_mark);
    end
  endtask

  ////////////////////////////////////////
  // Checks on the DUT ports
  ////////////////////////////////////////

  a_ready : assert property (@(posedge clk) disable iff (!arst_n) id_ready == exp_ready)
    else report_mismatch("id_ready_o", 32'($sampled(exp_ready)), 32'($sampled(id_ready)));

  a_valid : assert property (@(posedge clk) disable iff (!arst_n) id_valid == exp_valid)
    else report_mismatch("id_valid_o", 32'($sampled(exp_valid)), 32'($sampled(id_valid)));

  a_out_valid : assert property (@(posedge clk) disable iff (!arst_n)
                                 id_ex_pipe.valid == exp_q.valid)
    else report_mismatch("id_ex_pipe_o.valid", 32'($sampled(exp_q.valid)),
                         32'($sampled(id_ex_pipe.valid)));

  a_out_pc : assert property (@(posedge clk) disable iff (!arst_n)
                              exp_q.valid |-> id_ex_pipe.pc == exp_q.pc)
    else report_mismatch("id_ex_pipe_o.pc", $sampled(exp_q.pc), $sampled(id_ex_pipe.pc));

  a_out_dec : assert property (@(posedge clk) disable iff (!arst_n)
                               exp_q.valid |-> dec_vec(id_ex_pipe.decode) == exp_q.dec)
    else report_mismatch("id_ex_pipe_o.decode", 32'($sampled(exp_q.dec)),
                         32'(dec_vec($sampled(id_ex_pipe.decode))));

  a_out_op_a : assert property (@(posedge clk) disable iff (!arst_n)
                                exp_q.valid |-> id_ex_pipe.operand_a == exp_q.op_a)
    else report_mismatch("id_ex_pipe_o.operand_a", $sampled(exp_q.op_a),
                         $sampled(id_ex_pipe.operand_a));

  a_out_op_b : assert property (@(posedge clk) disable iff (!arst_n)
                                exp_q.valid |-> id_ex_pipe.operand_b == exp_q.op_b)
    else report_mismatch("id_ex_pipe_o.operand_b", $sampled(exp_q.op_b),
                         $sampled(id_ex_pipe.operand_b));

  a_stall : assert property (@(posedge clk) disable iff (!arst_n)
                             !ex_ready |=> $stable(id_ex_pipe))
    else report_failure("id_ex_pipe_o changed while ex_ready_i was low");

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  initial begin
    logic [31:0] instr;
    logic [31:0] rnd;
    rf_data_t    x0_val;
    clk      = 1'b0;
    seed     = 85540;
    err_cnt  = 0;
    err_mark = 0;
    n_pass   = 0;
    n_fail   = 0;
    pc_next  = 32'h0000_1000;
    nxt_if   = '0;
    nxt_dec  = '0;
    go_idle();
    for (int i = 0; i < RF_DEPTH; i++) begin
      shadow[i] = '0;
    end
    arst_n     <= 1'b0;
    if_id_pipe <= '0;
    wb         <= '0;
    ctrl       <= '0;
    ex_ready   <= 1'b1;
    cur_q      <= '0;
    exp_q      <= '0;
    repeat (RESET_CYCLES) @(posedge clk);
    arst_n <= 1'b1;

    // Encodings outside the decoded set
    start_test();
    for (int i = 0; i < N_ILLEGAL; i++) begin
      load_instr(illegal_instr(), 1'b0, DEC_ILLEGAL);
      step_cycle();
    end
    close_test("illegal_decode");

    // Every decoded class twice
    start_test();
    for (int i = 0; i < N_LEGAL; i++) begin
      instr = legal_instr(i % 14);
      load_instr(instr, 1'b0, legal_dec(i % 14));
      step_cycle();
    end
    close_test("legal_decode");

    // Halt holds the instruction and kill flushes it with or without halt
    start_test();
    load_instr(legal_instr(0), 1'b0, DEC_ALU);
    nxt_ctrl.halt_id = 1'b1;
    repeat (3) step_cycle();
    nxt_ctrl.kill_id = 1'b1;
    repeat (2) step_cycle();
    nxt_ctrl.halt_id = 1'b0;
    step_cycle();
    nxt_ctrl = '0;
    load_instr(legal_instr(2), 1'b0, DEC_MUL);
    step_cycle();
    close_test("halt_kill");

    // A dummy writeback gives x0 a real value that only dummy reads see
    start_test();
    x0_val        = $random(seed) | 32'h1;
    nxt_wb.we     = 1'b1;
    nxt_wb.dummy  = 1'b1;
    nxt_wb.waddr  = '0;
    nxt_wb.wdata  = x0_val;
    step_cycle();
    go_idle();
    step_cycle();
    load_instr(ADD_X5_X0_X0, 1'b0, DEC_ALU);
    step_cycle();
    load_instr(ADD_X5_X0_X0, 1'b1, DEC_ALU);
    step_cycle();
    // A regular write to x0 is dropped
    nxt_if.instr_valid = 1'b0;
    nxt_wb.we          = 1'b1;
    nxt_wb.dummy       = 1'b0;
    nxt_wb.wdata       = ~x0_val;
    step_cycle();
    go_idle();
    step_cycle();
    load_instr(ADD_X5_X0_X0, 1'b1, DEC_ALU);
    step_cycle();
    close_test("x0_rule");

    // Random writebacks with reads that often hit the register being written
    start_test();
    for (int i = 0; i < N_FWD; i++) begin
      rnd          = $random(seed);
      nxt_wb.we    = rnd[0];
      nxt_wb.dummy = rnd[1] & rnd[2];
      nxt_wb.waddr = rnd[7:3];
      nxt_wb.wdata = $random(seed);
      instr = {7'h00, rnd[8] ? rnd[7:3] : rnd[16:12], rnd[21:17], 3'b000, rnd[26:22],
               OPCODE_OP};
      load_instr(instr, rnd[27] & rnd[28], DEC_ALU);
      step_cycle();
    end
    close_test("operand_forward");

    // One item sits in EX while the next one waits in ID until EX frees up
    start_test();
    load_instr(legal_instr(4), 1'b0, DEC_LOAD);
    step_cycle();
    load_instr(legal_instr(5), 1'b0, DEC_STORE);
    nxt_ex_ready = 1'b0;
    repeat (4) step_cycle();
    nxt_ex_ready = 1'b1;
    step_cycle();
    close_test("back_pressure");

    $display("tests passed %0d failed %0d, check errors %0d", n_pass, n_fail, err_cnt);
    if (n_fail == 0 && err_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
src/id_pkg.sv
src/id_regfile.sv
src/id_decoder.sv
src/id_operand_read.sv
src/id_pipe_ctrl.sv
src/id_stage.sv
dv/tb_id_stage.sv

// ==== src/id_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module id_decoder (
  input  wire [31:0]       instr_i,
  input  wire              instr_valid_i,
  output id_pkg::decode_t  decode_o
);

  import id_pkg::*;

  logic [2:0] funct3;
  logic [6:0] funct7;
  decode_t    dec;
  logic       illegal;

  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  ////////////////////////////////////////
  // Raw decode
  ////////////////////////////////////////

  always_comb begin
    dec     = '0;
    illegal = 1'b0;
    // Register fields are taken from their fixed positions for every format
    dec.rs1 = instr_i[19:15];
    dec.rs2 = instr_i[24:20];
    dec.rd  = instr_i[11:7];
    case (instr_i[6:0])
      OPCODE_OP: begin
        dec.rf_we = 1'b1;
        dec.rf_re = 2'b11;
        if (funct7 == 7'b0000001) begin
          // MUL, MULH, MULHSU and MULHU, the divides are not supported
          dec.mul_en = 1'b1;
          illegal    = funct3[2];
        end else if (funct7 == 7'b0000000) begin
          dec.alu_en = 1'b1;
        end else if (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101)) begin
          // SUB and SRA
          dec.alu_en = 1'b1;
        end else begin
          illegal = 1'b1;
        end
      end
      OPCODE_OPIMM: begin
        dec.alu_en = 1'b1;
        dec.rf_we  = 1'b1;
        dec.rf_re  = 2'b01;
        // Shift immediates constrain the upper bits
        if (funct3 == 3'b001) illegal = (funct7 != 7'b0000000);
        if (funct3 == 3'b101) illegal = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
      end
      OPCODE_LOAD: begin
        dec.lsu_en = 1'b1;
        dec.rf_we  = 1'b1;
        dec.rf_re  = 2'b01;
        illegal    = (funct3 == 3'b011) || (funct3 == 3'b110) || (funct3 == 3'b111);
      end
      OPCODE_STORE: begin
        dec.lsu_en = 1'b1;
        dec.rf_re  = 2'b11;
        illegal    = (funct3 > 3'b010);
      end
      OPCODE_MISC_MEM: begin
        // Only FENCE.I is recognized here
        dec.fencei_insn = 1'b1;
        illegal         = (funct3 != 3'b001);
      end
      OPCODE_SYSTEM: begin
        if (funct3 == 3'b000) begin
          case (instr_i)
            32'h0000_0073: dec.ecall_insn = 1'b1;
            32'h0010_0073: dec.ebrk_insn  = 1'b1;
            32'h3020_0073: dec.mret_insn  = 1'b1;
            32'h1050_0073: dec.wfi_insn   = 1'b1;
            default:       illegal        = 1'b1;
          endcase
        end else begin
          // CSRRW, CSRRS and CSRRC with a register source
          dec.rf_we = 1'b1;
          dec.rf_re = 2'b01;
          case (funct3)
            3'b001:  dec.csr_op = CSR_OP_WRITE;
            3'b010:  dec.csr_op = CSR_OP_SET;
            3'b011:  dec.csr_op = CSR_OP_CLEAR;
            default: illegal    = 1'b1;
          endcase
        end
      end
      default: illegal = 1'b1;
    endcase
  end

  // Illegal or absent instructions leave only the register fields behind
  always_comb begin
    decode_o = dec;
    if (illegal || !instr_valid_i) begin
      decode_o              = '0;
      decode_o.rs1          = dec.rs1;
      decode_o.rs2          = dec.rs2;
      decode_o.rd           = dec.rd;
      decode_o.illegal_insn = illegal && instr_valid_i;
    end
  end

  always_comb begin
    if (instr_valid_i) begin
      a_instr_known : assert (!$isunknown(instr_i))
        else $error("id_decoder: valid instruction has X bits, instr %h", instr_i);
    end
    if (decode_o.illegal_insn) begin
      a_illegal_no_side_effect : assert (!(decode_o.alu_en || decode_o.mul_en ||
          decode_o.lsu_en || decode_o.rf_we || decode_o.ecall_insn || decode_o.ebrk_insn ||
          decode_o.mret_insn || decode_o.wfi_insn || decode_o.fencei_insn ||
          decode_o.csr_op != CSR_OP_READ))
        else $error("id_decoder: illegal instruction %h has a side effect", instr_i);
    end
  end

endmodule

`default_nettype wire

// ==== src/id_operand_read.sv ====
`timescale 1ns/1ps
`default_nettype none

module id_operand_read (
  input  wire id_pkg::decode_t  decode_i,
  input  wire                   dummy_i,
  input  wire id_pkg::wb_t      wb_i,
  output id_pkg::rf_addr_t      rf_raddr_o [id_pkg::NUM_READ_PORTS],
  input  wire id_pkg::rf_data_t rf_rdata_i [id_pkg::NUM_READ_PORTS],
  output id_pkg::rf_data_t      operand_a_o,
  output id_pkg::rf_data_t      operand_b_o
);

  import id_pkg::*;

  rf_data_t operand [NUM_READ_PORTS];

  // Port 0 serves rs1 and port 1 serves rs2
  always_comb begin
    rf_raddr_o[0] = decode_i.rs1;
    rf_raddr_o[1] = decode_i.rs2;
  end

  ////////////////////////////////////////
  // Forwarding and the x0 rule
  ////////////////////////////////////////

  always_comb begin
    for (int unsigned p = 0; p < NUM_READ_PORTS; p++) begin
      if (rf_raddr_o[p] == '0) begin
        // Regular code sees zero, dummy code sees the stored x0 value
        operand[p] = dummy_i ? rf_rdata_i[p] : '0;
      end else if (wb_i.we && (wb_i.waddr == rf_raddr_o[p])) begin
        // Write lands in the array next cycle, so bypass it now
        operand[p] = wb_i.wdata;
      end else begin
        operand[p] = rf_rdata_i[p];
      end
    end
  end

  assign operand_a_o = operand[0];
  assign operand_b_o = operand[1];

  // x0 rules for both ports, only where the instruction really reads the register
  always_comb begin
    for (int unsigned p = 0; p < NUM_READ_PORTS; p++) begin
      if (decode_i.rf_re[p] && (rf_raddr_o[p] == '0) && !dummy_i) begin
        a_non_dummy_reads_zero : assert (operand[p] == '0)
          else $error("id_operand_read: regular read of x0 on port %0d gave %h", p, operand[p]);
      end
      if (decode_i.rf_re[p] && (rf_raddr_o[p] == '0) && dummy_i) begin
        a_dummy_reads_x0 : assert (operand[p] == rf_rdata_i[p])
          else $error("id_operand_read: dummy read of x0 on port %0d gave %h", p, operand[p]);
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/id_pipe_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module id_pipe_ctrl (
  input  wire                      clk,
  input  wire                      arst_n_i,
  input  wire id_pkg::if_id_pipe_t if_id_pipe_i,
  input  wire id_pkg::decode_t     decode_i,
  input  wire id_pkg::rf_data_t    operand_a_i,
  input  wire id_pkg::rf_data_t    operand_b_i,
  input  wire id_pkg::ctrl_t       ctrl_i,
  input  wire                      ex_ready_i,
  output logic                     id_ready_o,
  output logic                     id_valid_o,
  output id_pkg::id_ex_pipe_t      id_ex_pipe_o
);

  import id_pkg::*;

  id_ex_pipe_t id_ex_pipe_d;

  ////////////////////////////////////////
  // Handshake
  ////////////////////////////////////////

  // Kill flushes the stage, so it reports valid low but still consumes the input
  assign id_valid_o = if_id_pipe_i.instr_valid && !ctrl_i.halt_id && !ctrl_i.kill_id;

  // Halt freezes the stage unless it is also being killed
  assign id_ready_o = ctrl_i.kill_id || (!ctrl_i.halt_id && ex_ready_i);

  // Merge fetch information, decode and operands into one EX payload
  always_comb begin
    id_ex_pipe_d.valid     = id_valid_o;
    id_ex_pipe_d.pc        = if_id_pipe_i.pc;
    id_ex_pipe_d.decode    = decode_i;
    id_ex_pipe_d.operand_a = operand_a_i;
    id_ex_pipe_d.operand_b = operand_b_i;
  end

  // The ID/EX register only moves when EX can take a new item
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      id_ex_pipe_o <= '0;
    end else if (ex_ready_i) begin
      id_ex_pipe_o <= id_ex_pipe_d;
    end
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  a_halt :
    assert property (@(posedge clk) disable iff (!arst_n_i)
                     (ctrl_i.halt_id && !ctrl_i.kill_id) |-> (!id_ready_o && !id_valid_o))
      else $error("id_pipe_ctrl: halt without kill must give ready and valid low");

  a_kill :
    assert property (@(posedge clk) disable iff (!arst_n_i)
                     ctrl_i.kill_id |-> (id_ready_o && !id_valid_o))
      else $error("id_pipe_ctrl: kill must give ready high and valid low");

  // Under back-pressure EX keeps its item untouched
  a_hold_on_stall :
    assert property (@(posedge clk) disable iff (!arst_n_i)
                     !ex_ready_i |=> $stable(id_ex_pipe_o))
      else $error("id_pipe_ctrl: ID/EX payload changed while EX was stalled");

endmodule

`default_nettype wire

// ==== src/id_pkg.sv ====
`default_nettype none

package id_pkg;

  ////////////////////////////////////////
  // Sizes and opcodes
  ////////////////////////////////////////

  localparam int unsigned XLEN           = 32;
  localparam int unsigned RF_DEPTH       = 32;
  localparam int unsigned RF_ADDR_W      = 5;
  localparam int unsigned NUM_READ_PORTS = 2;

  // Major opcodes of the RV32I subset handled by the decoder
  localparam logic [6:0] OPCODE_OP       = 7'h33;
  localparam logic [6:0] OPCODE_OPIMM    = 7'h13;
  localparam logic [6:0] OPCODE_LOAD     = 7'h03;
  localparam logic [6:0] OPCODE_STORE    = 7'h23;
  localparam logic [6:0] OPCODE_SYSTEM   = 7'h73;
  localparam logic [6:0] OPCODE_MISC_MEM = 7'h0f;

  ////////////////////////////////////////
  // Shared types
  ////////////////////////////////////////

  typedef logic [RF_ADDR_W-1:0] rf_addr_t;
  typedef logic [XLEN-1:0]      rf_data_t;

  // CSR_OP_READ is also the idle value, it has no write side effect
  typedef enum logic [1:0] {
    CSR_OP_READ  = 2'b00,
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,
    CSR_OP_CLEAR = 2'b11
  } csr_opcode_e;

  // Payload handed over from fetch
  typedef struct packed {
    logic        instr_valid;
    logic [31:0] instr;
    logic        dummy;
    logic [31:0] pc;
  } if_id_pipe_t;

  // Everything the decoder knows about one instruction
  typedef struct packed {
    logic        alu_en;
    logic        mul_en;
    logic        lsu_en;
    logic        rf_we;
    logic        ecall_insn;
    logic        ebrk_insn;
    logic        mret_insn;
    logic        wfi_insn;
    logic        fencei_insn;
    csr_opcode_e csr_op;
    logic [NUM_READ_PORTS-1:0] rf_re;
    rf_addr_t    rs1;
    rf_addr_t    rs2;
    rf_addr_t    rd;
    logic        illegal_insn;
  } decode_t;

  // Single-cycle write strobe coming back from writeback
  typedef struct packed {
    logic     we;
    logic     dummy;
    rf_addr_t waddr;
    rf_data_t wdata;
  } wb_t;

  // Level requests from the controller
  typedef struct packed {
    logic halt_id;
    logic kill_id;
  } ctrl_t;

  typedef struct packed {
    logic     valid;
    logic [31:0] pc;
    decode_t  decode;
    rf_data_t operand_a;
    rf_data_t operand_b;
  } id_ex_pipe_t;

endpackage

`default_nettype wire

// ==== src/id_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module id_regfile (
  input  wire                   clk,
  input  wire                   arst_n_i,
  input  wire id_pkg::rf_addr_t raddr_i [id_pkg::NUM_READ_PORTS],
  output id_pkg::rf_data_t      rdata_o [id_pkg::NUM_READ_PORTS],
  input  wire id_pkg::wb_t      wb_i
);

  import id_pkg::*;

  rf_data_t            regs_q [RF_DEPTH];
  logic [RF_DEPTH-1:0] we_dec;

  // One write enable per entry
  // Entry 0 only accepts writes that come from a dummy instruction
  always_comb begin
    for (int unsigned i = 0; i < RF_DEPTH; i++) begin
      we_dec[i] = wb_i.we && (wb_i.waddr == rf_addr_t'(i)) && ((i != 0) || wb_i.dummy);
    end
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int unsigned i = 0; i < RF_DEPTH; i++) begin
        regs_q[i] <= '0;
      end
    end else begin
      for (int unsigned i = 0; i < RF_DEPTH; i++) begin
        if (we_dec[i]) begin
          regs_q[i] <= wb_i.wdata;
        end
      end
    end
  end

  // Reads are asynchronous, the same-cycle write is handled by forwarding outside
  always_comb begin
    for (int unsigned p = 0; p < NUM_READ_PORTS; p++) begin
      rdata_o[p] = regs_q[raddr_i[p]];
    end
  end

  // Writeback must never push X into the array
  a_wdata_known :
    assert property (@(posedge clk) disable iff (!arst_n_i) wb_i.we |-> !$isunknown(wb_i.wdata))
      else $error("id_regfile: write to x%0d with unknown data", wb_i.waddr);

endmodule

`default_nettype wire

// ==== src/id_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module id_stage (
  input  wire                      clk,
  input  wire                      arst_n_i,
  input  wire id_pkg::if_id_pipe_t if_id_pipe_i,
  input  wire id_pkg::wb_t         wb_i,
  input  wire id_pkg::ctrl_t       ctrl_i,
  input  wire                      ex_ready_i,
  output logic                     id_ready_o,
  output logic                     id_valid_o,
  output id_pkg::id_ex_pipe_t      id_ex_pipe_o
);

  import id_pkg::*;

  decode_t  decode;
  rf_addr_t rf_raddr [NUM_READ_PORTS];
  rf_data_t rf_rdata [NUM_READ_PORTS];
  rf_data_t operand_a;
  rf_data_t operand_b;

  ////////////////////////////////////////
  // Decode and operand read in parallel
  ////////////////////////////////////////

  id_decoder u_decoder (
    .instr_i       (if_id_pipe_i.instr),
    .instr_valid_i (if_id_pipe_i.instr_valid),
    .decode_o      (decode)
  );

  // Writeback goes straight to the array and to the forwarding path
  id_regfile u_regfile (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .raddr_i  (rf_raddr),
    .rdata_o  (rf_rdata),
    .wb_i     (wb_i)
  );

  id_operand_read u_operand_read (
    .decode_i    (decode),
    .dummy_i     (if_id_pipe_i.dummy),
    .wb_i        (wb_i),
    .rf_raddr_o  (rf_raddr),
    .rf_rdata_i  (rf_rdata),
    .operand_a_o (operand_a),
    .operand_b_o (operand_b)
  );

  // Handshake and the ID/EX register
  id_pipe_ctrl u_pipe_ctrl (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .if_id_pipe_i (if_id_pipe_i),
    .decode_i     (decode),
    .operand_a_i  (operand_a),
    .operand_b_i  (operand_b),
    .ctrl_i       (ctrl_i),
    .ex_ready_i   (ex_ready_i),
    .id_ready_o   (id_ready_o),
    .id_valid_o   (id_valid_o),
    .id_ex_pipe_o (id_ex_pipe_o)
  );

endmodule

`default_nettype wire
